// ==== hdl/bitClockGen.sv ====
`default_nettype none

module bitClockGen (
    input  logic         busClk,
    input  logic         arstN,
    input  logic [15:0]  clocksPerBit,
    output logic         bitStrobe,
    output logic [15:0]  bitPhase
);

    logic wrap;

    // Comparing against the live period lets a shorter one cut the bit short
    always_comb begin
        wrap = (clocksPerBit != 16'd0) && (bitPhase >= clocksPerBit - 16'd1);
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            bitPhase  <= 16'd0;
            bitStrobe <= 1'b0;
        end else if (clocksPerBit == 16'd0) begin
            // Period of zero parks the counter
            bitPhase  <= 16'd0;
            bitStrobe <= 1'b0;
        end else if (wrap) begin
            bitPhase  <= 16'd0;
            bitStrobe <= 1'b1;
        end else begin
            bitPhase  <= bitPhase + 16'd1;
            bitStrobe <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dacMonitor.sv ====
`default_nettype none

`include "stc_defs.svh"

module dacMonitor (
    input  logic                   busClk,
    input  logic                   arstN,
    input  stcPkg::stcCfg          cfg,
    input  logic                   bitStrobe,
    input  logic [15:0]            bitPhase,
    output logic [`STC_DAC_W-1:0]  dac0,
    output logic [`STC_DAC_W-1:0]  dac1,
    output logic [`STC_DAC_W-1:0]  dac2
);

    logic [11:0]                     pilotPhase;
    logic [2:0][`STC_DAC_W-1:0]      dacQ;

    // Decodes one select field into the sample it routes
    function automatic logic [`STC_DAC_W-1:0] pickSource(input logic [3:0] sel);
        stcPkg::dacSource src;
        src = stcPkg::dacSource'(sel);
        case (src)
            stcPkg::srcBitPhase:   pickSource = bitPhase[`STC_DAC_W-1:0];
            stcPkg::srcPilotPhase: pickSource = pilotPhase;
            stcPkg::srcBitStrobe:  pickSource = {`STC_DAC_W{bitStrobe}};
            default:               pickSource = '0;
        endcase
    endfunction

    // Inverted spectrum runs the pilot backwards, wrapping modulo 4096
    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            pilotPhase <= 12'd0;
        end else if (cfg.spectrumInvert) begin
            pilotPhase <= pilotPhase - cfg.pilotOffset;
        end else begin
            pilotPhase <= pilotPhase + cfg.pilotOffset;
        end
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            dacQ <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                dacQ[i] <= pickSource(cfg.dacSel[i]);
            end
        end
    end

    assign dac0 = dacQ[0];
    assign dac1 = dacQ[1];
    assign dac2 = dacQ[2];

endmodule

`default_nettype wire

// ==== hdl/stcBusBridge.sv ====
`default_nettype none

module stcBusBridge (
    input  logic             busClk,
    input  logic             arstN,
    input  logic             req,
    input  stcPkg::busReq    reqBus,
    output logic             ack,
    output stcPkg::busRsp    rspBus,
    output stcPkg::regWrite  regBus,
    input  logic [31:0]      regRdData
);

    stcPkg::bridgeState state;

    // The register strobe lives for exactly the one access cycle
    always_comb begin
        regBus.cs     = (state == stcPkg::access);
        regBus.wrLane = (state == stcPkg::access && reqBus.write) ? reqBus.byteEn : 4'b0000;
        regBus.addr   = reqBus.addr;
        regBus.data   = reqBus.wrData;
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            state <= stcPkg::idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                stcPkg::idle: begin
                    if (req) begin
                        state <= stcPkg::access;
                    end
                end
                stcPkg::access: begin
                    state <= stcPkg::done;
                    ack   <= 1'b1;
                end
                stcPkg::done: begin
                    // Host keeps req high to stall, ack holds until it lets go
                    if (!req) begin
                        state <= stcPkg::idle;
                        ack   <= 1'b0;
                    end
                end
                default: begin
                    state <= stcPkg::idle;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // Read data is sampled before the bank applies any write of the same access
    always_ff @(posedge busClk) begin
        if (state == stcPkg::access) begin
            rspBus.rdData <= regRdData;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/stcPkg.sv ====
`default_nettype none

`include "stc_defs.svh"

package stcPkg;

    // Host side request, held stable while req is high
    typedef struct packed {
        logic                     write;
        logic [`STC_ADDR_W-1:0]   addr;
        logic [3:0]               byteEn;
        logic [31:0]              wrData;
    } busReq;

    typedef struct packed {
        logic [31:0] rdData;
    } busRsp;

    // One strobe per host transaction, wrLane is zero for reads
    typedef struct packed {
        logic                     cs;
        logic [3:0]               wrLane;
        logic [`STC_ADDR_W-1:0]   addr;
        logic [31:0]              data;
    } regWrite;

    typedef struct packed {
        logic [15:0]       clocksPerBit;
        logic              spectrumInvert;
        logic [11:0]       pilotOffset;
        logic [2:0][3:0]   dacSel;
    } stcCfg;

    typedef enum logic [1:0] {
        idle,
        access,
        done
    } bridgeState;

    // Codes 4 to 15 are reserved and decode as srcZero
    typedef enum logic [3:0] {
        srcZero       = 4'd0,
        srcBitPhase   = 4'd1,
        srcPilotPhase = 4'd2,
        srcBitStrobe  = 4'd3
    } dacSource;

endpackage

`default_nettype wire

// ==== hdl/stcRegs.sv ====
`default_nettype none

`include "stc_defs.svh"

module stcRegs (
    input  logic             busClk,
    input  logic             arstN,
    input  stcPkg::regWrite  regBus,
    output logic [31:0]      rdData,
    output stcPkg::stcCfg    cfg
);

    // All fields update at the edge that ends the access cycle
    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            cfg <= '0;
        end else if (regBus.cs) begin
            // Lane 0
            if (regBus.wrLane[0]) begin
                case (regBus.addr)
                    `STC_CLOCKS_PER_BIT: cfg.clocksPerBit[7:0] <= regBus.data[7:0];
                    `STC_PILOT_OFFSET:   cfg.pilotOffset[7:0] <= regBus.data[7:0];
                    `STC_DAC_SELECT:     cfg.dacSel[0] <= regBus.data[3:0];
                    default: ;
                endcase
            end
            // Lane 1
            if (regBus.wrLane[1]) begin
                case (regBus.addr)
                    `STC_CLOCKS_PER_BIT: cfg.clocksPerBit[15:8] <= regBus.data[15:8];
                    `STC_PILOT_OFFSET:   cfg.pilotOffset[11:8] <= regBus.data[11:8];
                    `STC_DAC_SELECT:     cfg.dacSel[1] <= regBus.data[11:8];
                    default: ;
                endcase
            end
            // Lane 2, lane 3 has no fields behind it
            if (regBus.wrLane[2]) begin
                case (regBus.addr)
                    `STC_CLOCKS_PER_BIT: cfg.spectrumInvert <= regBus.data[16];
                    `STC_DAC_SELECT:     cfg.dacSel[2] <= regBus.data[19:16];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rdData = 32'h0;
        if (regBus.cs) begin
            case (regBus.addr)
                `STC_CLOCKS_PER_BIT: begin
                    rdData = {15'h0, cfg.spectrumInvert, cfg.clocksPerBit};
                end
                `STC_PILOT_OFFSET: begin
                    rdData = {20'h0, cfg.pilotOffset};
                end
                `STC_DAC_SELECT: begin
                    rdData = {
                        12'h0, cfg.dacSel[2],
                        4'h0, cfg.dacSel[1],
                        4'h0, cfg.dacSel[0]
                    };
                end
                default: begin
                    rdData = 32'h0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/stcTop.sv ====
`default_nettype none

`include "stc_defs.svh"

module stcTop (
    input  logic                   busClk,
    input  logic                   arstN,
    input  logic                   req,
    input  stcPkg::busReq          reqBus,
    output logic                   ack,
    output stcPkg::busRsp          rspBus,
    output logic                   bitStrobe,
    output logic [`STC_DAC_W-1:0]  dac0,
    output logic [`STC_DAC_W-1:0]  dac1,
    output logic [`STC_DAC_W-1:0]  dac2
);

    stcPkg::regWrite  regBus;
    stcPkg::stcCfg    cfg;
    logic [31:0]      regRdData;
    logic [15:0]      bitPhase;

    stcBusBridge u_stcBusBridge (
        .busClk    (busClk),
        .arstN     (arstN),
        .req       (req),
        .reqBus    (reqBus),
        .ack       (ack),
        .rspBus    (rspBus),
        .regBus    (regBus),
        .regRdData (regRdData)
    );

    stcRegs u_stcRegs (
        .busClk (busClk),
        .arstN  (arstN),
        .regBus (regBus),
        .rdData (regRdData),
        .cfg    (cfg)
    );

    bitClockGen u_bitClockGen (
        .busClk       (busClk),
        .arstN        (arstN),
        .clocksPerBit (cfg.clocksPerBit),
        .bitStrobe    (bitStrobe),
        .bitPhase     (bitPhase)
    );

    dacMonitor u_dacMonitor (
        .busClk    (busClk),
        .arstN     (arstN),
        .cfg       (cfg),
        .bitStrobe (bitStrobe),
        .bitPhase  (bitPhase),
        .dac0      (dac0),
        .dac1      (dac1),
        .dac2      (dac2)
    );

endmodule

`default_nettype wire

// ==== hdl/stc_defs.svh ====
`ifndef STC_DEFS_SVH
`define STC_DEFS_SVH

// Register address width on the host port
`define STC_ADDR_W 13

// Bit period in bits 15:0, spectrum inversion in bit 16
`define STC_CLOCKS_PER_BIT 13'h0040

// Pilot offset in bits 11:0
`define STC_PILOT_OFFSET 13'h0044

// DAC selects in bits 3:0, 11:8 and 19:16
`define STC_DAC_SELECT 13'h0048

// Width of each monitor DAC sample
`define STC_DAC_W 12

`endif

// ==== sources.f ====
+incdir+hdl
hdl/stcPkg.sv
hdl/stcBusBridge.sv
hdl/stcRegs.sv
hdl/bitClockGen.sv
hdl/dacMonitor.sv
hdl/stcTop.sv
verif/stcTop_sva.sv
verif/stcTb.sv

// ==== verif/stcTb.sv ====
`default_nettype none

`include "stc_defs.svh"

module stcTb;

    // About 2000 cycles of tests, so twice that ends a stuck run
    localparam int maxCycles = 4000;

    logic busClk = 1'b0;
    logic arstN;
    logic req;
    stcPkg::busReq reqBus;
    logic ack;
    stcPkg::busRsp rspBus;
    logic bitStrobe;
    logic [11:0] dac0;
    logic [11:0] dac1;
    logic [11:0] dac2;

    logic [31:0] rngState = 32'h3c8cabd6;
    logic [31:0] model [3];
    int errCount = 0;
    int testErrStart = 0;
    int passCount = 0;
    int failCount = 0;
    int cycles = 0;

    stcTop u_stcTop (
        .busClk(busClk), .arstN(arstN), .req(req), .reqBus(reqBus), .ack(ack),
        .rspBus(rspBus), .bitStrobe(bitStrobe), .dac0(dac0), .dac1(dac1), .dac2(dac2)
    );

    always #2 busClk = ~busClk;

    always @(posedge busClk) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", maxCycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Readback mismatches plus failures of the bound assertions
    function automatic int errorTotal();
        return errCount + u_stcTop.u_stcTopSva.failures;
    endfunction

    function automatic logic [12:0] regAddr(input int idx);
        return (idx == 0) ? `STC_CLOCKS_PER_BIT : (idx == 1) ? `STC_PILOT_OFFSET : `STC_DAC_SELECT;
    endfunction

    // Bits each byte lane may change in each register
    function automatic logic [31:0] laneMask(input int idx, input logic [3:0] be);
        logic [31:0] m [3][3];
        logic [31:0] r;
        m = '{'{32'hFF, 32'hFF00, 32'h10000}, '{32'hFF, 32'hF00, 32'h0},
              '{32'hF, 32'hF00, 32'hF0000}};
        r = 32'h0;
        for (int l = 0; l < 3; l++) begin
            if (be[l]) r = r | m[idx][l];
        end
        return r;
    endfunction

    task automatic runTransfer(input logic wr, input logic [12:0] addr, input logic [3:0] be,
                               input logic [31:0] data, output logic [31:0] rd);
        int extra;
        extra = nextRand() % 4;
        @(posedge busClk);
        reqBus <= {wr, addr, be, data};
        req <= 1'b1;
        do @(posedge busClk); while (!ack);
        rd = rspBus.rdData;
        repeat (extra) @(posedge busClk);
        req <= 1'b0;
        do @(posedge busClk); while (ack);
    endtask

    task automatic writeReg(input int idx, input logic [3:0] be, input logic [31:0] data);
        logic [31:0] rd;
        logic [31:0] m;
        m = laneMask(idx, be);
        runTransfer(1'b1, regAddr(idx), be, data, rd);
        model[idx] = (model[idx] & ~m) | (data & m);
    endtask

    task automatic checkReg(input int idx);
        logic [31:0] rd;
        runTransfer(1'b0, regAddr(idx), 4'h0, 32'h0, rd);
        assert (rd == model[idx]) else begin
            $display("[ERROR] reg%0d rdData expected %h got %h", idx, model[idx], rd);
            errCount++;
        end
    endtask

    task automatic countStrobes(input int window, output int n);
        n = 0;
        repeat (window) begin
            @(posedge busClk);
            if (bitStrobe) n++;
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            errCount++;
        end
    endtask

    task automatic endTest(input string name);
        if (errorTotal() == testErrStart) begin
            passCount++;
            $display("test %s passed", name);
        end else begin
            failCount++;
            $display("test %s failed with %0d errors", name, errorTotal() - testErrStart);
        end
        testErrStart = errorTotal();
    endtask

    initial begin
        int n;
        int p;
        logic [31:0] rd;
        logic [12:0] a;
        logic [11:0] prev;
        logic [11:0] prevPhase;
        logic prevStrobe;
        req = 1'b0;
        reqBus = '0;
        arstN = 1'b0;
        model = '{32'h0, 32'h0, 32'h0};
        repeat (3) @(posedge busClk);
        arstN <= 1'b1;

        countStrobes(20, n);
        checkValue("strobe count", 0, n);
        checkValue("ack", 0, ack);
        checkValue("dac0", 0, dac0);
        checkValue("dac1", 0, dac1);
        checkValue("dac2", 0, dac2);
        for (int i = 0; i < 3; i++) checkReg(i);
        endTest("reset");

        for (int i = 0; i < 3; i++) begin
            for (int be = 0; be < 16; be++) begin
                writeReg(i, be[3:0], nextRand());
                checkReg(i);
            end
        end
        endTest("byte lanes");

        for (int k = 0; k < 20; k++) begin
            a = 13'(nextRand());
            if (a == `STC_CLOCKS_PER_BIT || a == `STC_PILOT_OFFSET || a == `STC_DAC_SELECT)
                a = a + 13'd1;
            runTransfer(1'b0, a, 4'h0, 32'h0, rd);
            checkValue("unmapped rdData", 0, rd);
            runTransfer(1'b1, a, 4'hF, nextRand(), rd);
        end
        for (int i = 0; i < 3; i++) checkReg(i);
        endTest("unmapped");

        for (int k = 0; k < 16; k++) begin
            writeReg(1, 4'hF, nextRand());
            checkReg(1);
        end
        endTest("handshake");

        for (int k = 0; k < 3; k++) begin
            p = (k == 0) ? 1 : (k == 1) ? 5 : 2 + nextRand() % 39;
            writeReg(0, 4'b0011, p);
            repeat (2 * p + 4) @(posedge busClk);
            countStrobes(10 * p, n);
            checkValue("strobe count", 10, n);
        end
        writeReg(0, 4'b0011, 0);
        repeat (4) @(posedge busClk);
        countStrobes(50, n);
        checkValue("strobe count", 0, n);
        endTest("bit strobe");

        // Pilot phase on dac0, bit strobe on dac1 and bit phase on dac2
        writeReg(0, 4'b0011, 5);
        writeReg(2, 4'b0111, 32'h00010302);
        for (int inv = 0; inv < 2; inv++) begin
            writeReg(0, 4'b0100, inv << 16);
            writeReg(1, 4'b0011, nextRand());
            repeat (4) @(posedge busClk);
            prev = dac0;
            prevStrobe = bitStrobe;
            prevPhase = dac2;
            repeat (30) begin
                @(posedge busClk);
                checkValue("dac0", inv ? 12'(prev - model[1][11:0])
                                       : 12'(prev + model[1][11:0]), dac0);
                checkValue("dac1", prevStrobe ? 12'hFFF : 12'h0, dac1);
                // A period of 5 runs the phase from 0 to 4
                checkValue("dac2", (prevPhase == 12'd4) ? 12'd0 : prevPhase + 12'd1, dac2);
                prev = dac0;
                prevStrobe = bitStrobe;
                prevPhase = dac2;
            end
        end
        writeReg(2, 4'b0111, 32'h000F0804);
        repeat (3) @(posedge busClk);
        repeat (10) begin
            @(posedge busClk);
            checkValue("dac0", 0, dac0);
            checkValue("dac1", 0, dac1);
            checkValue("dac2", 0, dac2);
        end
        endTest("dac routing");

        $display("tests passed %0d failed %0d", passCount, failCount);
        if (errorTotal() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/stcTop_sva.sv ====
`default_nettype none

module stcTopSva (
    input wire logic         busClk,
    input wire logic         arstN,
    input wire logic         req,
    input wire logic         ack,
    input wire logic         bitStrobe,
    input wire logic [15:0]  clocksPerBit,
    input wire logic         spectrumInvert,
    input wire logic [11:0]  pilotOffset,
    input wire logic [3:0]   dac0Sel,
    input wire logic [11:0]  dac0
);

    logic [16:0] sinceStrobe;
    logic [15:0] cpbPrev;
    logic        cpbSteady;
    int          failures = 0;

    // Cycles since the last strobe, and whether the period held still over that stretch
    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            sinceStrobe <= '0;
            cpbPrev     <= '0;
            cpbSteady   <= 1'b0;
        end else begin
            cpbPrev <= clocksPerBit;
            if (bitStrobe) begin
                sinceStrobe <= 17'd1;
                cpbSteady   <= (clocksPerBit == cpbPrev);
            end else begin
                sinceStrobe <= sinceStrobe + 17'd1;
                cpbSteady   <= cpbSteady && (clocksPerBit == cpbPrev);
            end
        end
    end

    ackNeedsReq: assert property (@(posedge busClk) disable iff (!arstN)
        $rose(ack) |-> req)
        else begin
            $error("ack rose without req");
            failures++;
        end

    ackHolds: assert property (@(posedge busClk) disable iff (!arstN)
        (ack && req) |=> ack)
        else begin
            $error("ack dropped while req was high");
            failures++;
        end

    // A strobe seen now was issued under the period of the previous cycle
    strobePeriod: assert property (@(posedge busClk) disable iff (!arstN)
        (bitStrobe && cpbSteady && cpbPrev != 16'd0) |-> sinceStrobe == cpbPrev)
        else begin
            $error("bit strobe period differs from clocksPerBit");
            failures++;
        end

    // The DAC lags the accumulator by one cycle, so the step uses the offset from two back
    pilotStep: assert property (@(posedge busClk) disable iff (!arstN)
        ($past(dac0Sel) == 4'd2 && $past(dac0Sel, 2) == 4'd2) |->
        dac0 == ($past(spectrumInvert, 2) ? 12'($past(dac0) - $past(pilotOffset, 2))
                                          : 12'($past(dac0) + $past(pilotOffset, 2))))
        else begin
            $error("dac0 pilot phase step is wrong");
            failures++;
        end

endmodule

bind stcTop stcTopSva u_stcTopSva (
    .busClk         (busClk),
    .arstN          (arstN),
    .req            (req),
    .ack            (ack),
    .bitStrobe      (bitStrobe),
    .clocksPerBit   (cfg.clocksPerBit),
    .spectrumInvert (cfg.spectrumInvert),
    .pilotOffset    (cfg.pilotOffset),
    .dac0Sel        (cfg.dacSel[0]),
    .dac0           (dac0)
);

`default_nettype wire
